/* logic/button_ctrl.sv */
`timescale 1ns/100ps

module button_ctrl #(
  parameter int DEBOUNCE_CYCLES = 50000
) (
  input  logic clk,
  input  logic reset,
  input  logic btn_1,
  input  logic btn_2,
  input  logic btn_3,
  mode_if.src  modes
);

  localparam int DB_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [2:0]      btn_raw;
  logic [2:0]      sync_1;
  logic [2:0]      sync_2;
  logic [DB_W-1:0] db_cnt [3];
  logic [2:0]      press;

  assign btn_raw = {btn_3, btn_2, btn_1};

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= btn_raw;
      sync_2 <= sync_1;
    end
  end

  // counter parks at DEBOUNCE_CYCLES, so a held button fires once
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (reset || !sync_2[i]) begin
        db_cnt[i] <= '0;
      end else if (db_cnt[i] != DB_W'(DEBOUNCE_CYCLES)) begin
        db_cnt[i] <= db_cnt[i] + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      press[i] = sync_2[i] && (db_cnt[i] == DB_W'(DEBOUNCE_CYCLES - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      modes.main_mode <= pad_pkg::nt;
      modes.sub_mode  <= 8'd0;
      modes.clr_seq   <= 1'b0;
      modes.mode_chg  <= 1'b0;
    end else begin
      if (press[0]) begin
        modes.main_mode <= pad_pkg::pad_group_e'(modes.main_mode + 2'd1);
      end
      if (press[1]) begin
        modes.sub_mode <= modes.sub_mode + 8'd1;
      end
      modes.clr_seq  <= press[2];
      modes.mode_chg <= press[0] || press[1];
    end
  end

  // a held button must be released before it clears again
  a_clr_single : assert property (@(posedge clk) disable iff (reset)
    modes.clr_seq |=> !modes.clr_seq)
    else $error("clr_seq high on consecutive cycles");

endmodule

/* logic/link_pkg.sv */
package link_pkg;

  localparam int LANES    = 2;
  localparam int RECV_W   = 32;
  localparam int ERR_W    = 16;
  localparam int LOCK_RUN = 16;
  localparam int PRBS_W   = 7;

  // different seeds keep the two lanes from carrying the same pattern
  localparam logic [PRBS_W-1:0] PRBS_SEED [LANES] = '{7'h01, 7'h55};

  typedef logic [RECV_W-1:0] recv_cnt_t;
  typedef logic [ERR_W-1:0]  err_cnt_t;

  // x^7 + x^6 + 1 with bit 0 holding the newest bit
  function automatic logic prbs_fb(logic [PRBS_W-1:0] s);
    return s[6] ^ s[5];
  endfunction

  // one step back through the sequence
  function automatic logic [PRBS_W-1:0] prbs_prev(logic [PRBS_W-1:0] s);
    return {s[0] ^ s[6], s[6:1]};
  endfunction

endpackage

/* logic/lvds_test.sv */
`timescale 1ns/100ps

module lvds_test #(
  parameter int DEBOUNCE_CYCLES = 50000,
  parameter int SCAN_CYCLES     = 1000
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       btn_1,
  input  logic                       btn_2,
  input  logic                       btn_3,
  input  logic [link_pkg::LANES-1:0] din,
  output logic [link_pkg::LANES-1:0] dout,
  output logic [3:0]                 digit_sel,
  output logic [7:0]                 digit,
  output pad_pkg::pad_ctrl_t         nt_ctrl,
  output pad_pkg::pad_ctrl_t         et_ctrl,
  output pad_pkg::pad_ctrl_t         st_ctrl,
  output pad_pkg::pad_ctrl_t         sc_ctrl,
  output link_pkg::recv_cnt_t        recv_cnt,
  output link_pkg::err_cnt_t         err_cnt,
  output logic                       locked
);

  mode_if modes ();

  // ##########################################################################
  // buttons and modes
  button_ctrl #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) i_button_ctrl (
    .clk   (clk),
    .reset (reset),
    .btn_1 (btn_1),
    .btn_2 (btn_2),
    .btn_3 (btn_3),
    .modes (modes)
  );

  // ##########################################################################
  // link, pads and display
  prbs_link i_prbs_link (
    .clk      (clk),
    .reset    (reset),
    .modes    (modes),
    .din      (din),
    .dout     (dout),
    .recv_cnt (recv_cnt),
    .err_cnt  (err_cnt),
    .locked   (locked)
  );

  pad_ctrl_gen i_pad_ctrl_gen (
    .clk     (clk),
    .reset   (reset),
    .modes   (modes),
    .nt_ctrl (nt_ctrl),
    .et_ctrl (et_ctrl),
    .st_ctrl (st_ctrl),
    .sc_ctrl (sc_ctrl)
  );

  seg_display #(
    .SCAN_CYCLES (SCAN_CYCLES)
  ) i_seg_display (
    .clk       (clk),
    .reset     (reset),
    .modes     (modes),
    .err_cnt   (err_cnt),
    .digit_sel (digit_sel),
    .digit     (digit)
  );

endmodule

/* logic/mode_if.sv */
`timescale 1ns/100ps

interface mode_if;

  pad_pkg::pad_group_e main_mode;
  logic [7:0]          sub_mode;
  // single-cycle strobes
  logic                clr_seq;
  logic                mode_chg;

  modport src (output main_mode, output sub_mode, output clr_seq, output mode_chg);

  modport sink (input main_mode, input sub_mode, input clr_seq, input mode_chg);

endinterface

/* logic/pad_ctrl_gen.sv */
`timescale 1ns/100ps

module pad_ctrl_gen (
  input  logic               clk,
  input  logic               reset,
  mode_if.sink               modes,
  output pad_pkg::pad_ctrl_t nt_ctrl,
  output pad_pkg::pad_ctrl_t et_ctrl,
  output pad_pkg::pad_ctrl_t st_ctrl,
  output pad_pkg::pad_ctrl_t sc_ctrl
);

  logic [2:0]         por_cnt;
  logic               por_now;
  pad_pkg::pad_ctrl_t words [4];

  // word for the group under test
  function automatic pad_pkg::pad_ctrl_t active_word(logic [7:0] sub, logic por);
    pad_pkg::pad_ctrl_t w;
    w           = pad_pkg::PAD_IDLE;
    w.sel_rx_a  = 1'b1;
    w.sel_rx_b  = 1'b1;
    w.sel_tx_a  = 1'b1;
    w.sel_tx_b  = 1'b1;
    w.pd_bias_a = 1'b0;
    w.pd_bias_b = 1'b0;
    w.drv_str_a = sub[1:0];
    w.drv_str_b = sub[1:0];
    w.idset_a   = sub[3:2];
    w.idset_b   = sub[3:2];
    w.hyst_a    = sub[4];
    w.hyst_b    = sub[4];
    w.sr_a      = sub[5];
    w.sr_b      = sub[5];
    w.test_a    = sub[7:6];
    w.test_b    = sub[7:6];
    w.por       = por;
    return w;
  endfunction

  // por holds for 8 cycles, counting the cycle of mode_chg
  assign por_now = modes.mode_chg || (por_cnt != 3'd0);

  always_ff @(posedge clk) begin
    if (reset || modes.mode_chg) begin
      por_cnt <= 3'd7;
    end else if (por_cnt != 3'd0) begin
      por_cnt <= por_cnt - 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    for (int g = 0; g < 4; g++) begin
      if (reset) begin
        words[g] <= (g == int'(pad_pkg::nt)) ? active_word(8'd0, 1'b1) : pad_pkg::PAD_IDLE;
      end else if (g == int'(modes.main_mode)) begin
        words[g] <= active_word(modes.sub_mode, por_now);
      end else begin
        words[g] <= pad_pkg::PAD_IDLE;
      end
    end
  end

  assign nt_ctrl = words[int'(pad_pkg::nt)];
  assign et_ctrl = words[int'(pad_pkg::et)];
  assign st_ctrl = words[int'(pad_pkg::st)];
  assign sc_ctrl = words[int'(pad_pkg::sc)];

  a_one_biased : assert property (@(posedge clk) disable iff (reset)
    $onehot0(~{nt_ctrl.pd_bias_a, et_ctrl.pd_bias_a, st_ctrl.pd_bias_a, sc_ctrl.pd_bias_a}))
    else $error("more than one pad group biased");

endmodule

/* logic/pad_pkg.sv */
package pad_pkg;

  // one control word per pad group with the MSB first in pad ring bit order
  typedef struct packed {
    logic       sel_rx_a;
    logic       sel_rx_b;
    logic       sel_tx_a;
    logic       sel_tx_b;
    logic       pd_bias_a;
    logic       pd_bias_b;
    logic [1:0] idset_a;
    logic [1:0] idset_b;
    logic       hyst_a;
    logic       hyst_b;
    logic [1:0] drv_str_a;
    logic [1:0] drv_str_b;
    logic       sr_a;
    logic       sr_b;
    logic       puden_tx_a;
    logic       puden_tx_b;
    logic       puden_rx_a;
    logic       puden_rx_b;
    logic       pudpol_tx_a;
    logic       pudpol_tx_b;
    logic       pudpol_rx_a;
    logic       pudpol_rx_b;
    logic [1:0] test_a;
    logic [1:0] test_b;
    logic       por;
  } pad_ctrl_t;

  // group not under test keeps its bias powered down
  localparam pad_ctrl_t PAD_IDLE = '{pd_bias_a: 1'b1, pd_bias_b: 1'b1, default: '0};

  typedef enum logic [1:0] {nt = 2'd0, et = 2'd1, st = 2'd2, sc = 2'd3} pad_group_e;

endpackage

/* logic/prbs_link.sv */
`timescale 1ns/100ps

module prbs_link (
  input  logic                       clk,
  input  logic                       reset,
  mode_if.sink                       modes,
  input  logic [link_pkg::LANES-1:0] din,
  output logic [link_pkg::LANES-1:0] dout,
  output link_pkg::recv_cnt_t        recv_cnt,
  output link_pkg::err_cnt_t         err_cnt,
  output logic                       locked
);

  localparam int RUN_W  = $clog2(link_pkg::LOCK_RUN + 1);
  localparam int NERR_W = $clog2(link_pkg::LANES + 1);
  localparam int ERR_W  = link_pkg::ERR_W;

  logic [link_pkg::PRBS_W-1:0] tx_state [link_pkg::LANES];
  logic [link_pkg::PRBS_W-1:0] rx_state [link_pkg::LANES];
  logic [link_pkg::LANES-1:0]  rx_d;
  logic [link_pkg::LANES-1:0]  err;
  logic [NERR_W-1:0]           n_err;
  logic [ERR_W:0]              err_sum;
  logic [RUN_W-1:0]            run;

  // ##########################################################################
  // transmitter drives dout from bit 0 of the generator register
  always_ff @(posedge clk) begin
    for (int i = 0; i < link_pkg::LANES; i++) begin
      if (reset) begin
        tx_state[i] <= link_pkg::PRBS_SEED[i];
      end else begin
        tx_state[i] <= {tx_state[i][5:0], link_pkg::prbs_fb(tx_state[i])};
      end
    end
  end

  always_comb begin
    for (int i = 0; i < link_pkg::LANES; i++) begin
      dout[i] = tx_state[i][0];
    end
  end

  // ##########################################################################
  // receiver reset values line up with the transmitter for a direct loopback
  always_ff @(posedge clk) begin
    for (int i = 0; i < link_pkg::LANES; i++) begin
      if (reset) begin
        rx_d[i]     <= link_pkg::PRBS_SEED[i][1];
        rx_state[i] <= link_pkg::prbs_prev(link_pkg::prbs_prev(link_pkg::PRBS_SEED[i]));
      end else begin
        rx_d[i] <= din[i];
        if (locked) begin
          rx_state[i] <= {rx_state[i][5:0], link_pkg::prbs_fb(rx_state[i])};
        end else begin
          rx_state[i] <= {rx_state[i][5:0], rx_d[i]};
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < link_pkg::LANES; i++) begin
      err[i] = rx_d[i] ^ link_pkg::prbs_fb(rx_state[i]);
    end
  end

  assign n_err   = NERR_W'($countones(err));
  assign err_sum = {1'b0, err_cnt} + (ERR_W + 1)'(n_err);

  always_ff @(posedge clk) begin
    if (reset || modes.clr_seq) begin
      locked   <= 1'b0;
      run      <= '0;
      recv_cnt <= '0;
      err_cnt  <= '0;
    end else if (locked) begin
      if (recv_cnt != '1) begin
        recv_cnt <= recv_cnt + 1'b1;
      end
      err_cnt <= err_sum[ERR_W] ? '1 : err_sum[ERR_W-1:0];
    end else if (|err) begin
      run <= '0;
    end else if (run == RUN_W'(link_pkg::LOCK_RUN - 1)) begin
      locked <= 1'b1;
      run    <= '0;
    end else begin
      run <= run + 1'b1;
    end
  end

  a_err_frozen : assert property (@(posedge clk) disable iff (reset)
    !locked && !modes.clr_seq |=> $stable(err_cnt))
    else $error("err_cnt moved while unlocked");

endmodule

/* logic/seg_display.sv */
`timescale 1ns/100ps

module seg_display #(
  parameter int SCAN_CYCLES = 1000
) (
  input  logic               clk,
  input  logic               reset,
  mode_if.sink               modes,
  input  link_pkg::err_cnt_t err_cnt,
  output logic [3:0]         digit_sel,
  output logic [7:0]         digit
);

  localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);

  logic [SCAN_W-1:0] scan_cnt;
  logic [3:0]        nibble;

  // segments active high in gfedcba order
  function automatic logic [6:0] hex_seg(logic [3:0] v);
    case (v)
      4'h0: return 7'h3f;
      4'h1: return 7'h06;
      4'h2: return 7'h5b;
      4'h3: return 7'h4f;
      4'h4: return 7'h66;
      4'h5: return 7'h6d;
      4'h6: return 7'h7d;
      4'h7: return 7'h07;
      4'h8: return 7'h7f;
      4'h9: return 7'h6f;
      4'ha: return 7'h77;
      4'hb: return 7'h7c;
      4'hc: return 7'h39;
      4'hd: return 7'h5e;
      4'he: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  // the single 0 in digit_sel rotates from digit 0 up to digit 3
  always_ff @(posedge clk) begin
    if (reset) begin
      scan_cnt  <= '0;
      digit_sel <= 4'b1110;
    end else if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1)) begin
      scan_cnt  <= '0;
      digit_sel <= {digit_sel[2:0], digit_sel[3]};
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  always_comb begin
    case (digit_sel)
      4'b1110: nibble = {2'b00, modes.main_mode};
      4'b1101: nibble = modes.sub_mode[7:4];
      4'b1011: nibble = err_cnt[7:4];
      default: nibble = err_cnt[3:0];
    endcase
  end

  // active low with the decimal point kept dark
  assign digit = {1'b1, ~hex_seg(nibble)};

  a_one_digit : assert property (@(posedge clk) disable iff (reset)
    $onehot(~digit_sel))
    else $error("digit_sel must select exactly one digit");

endmodule

/* lvds_test.f */
+incdir+test
logic/pad_pkg.sv
logic/link_pkg.sv
logic/mode_if.sv
logic/button_ctrl.sv
logic/prbs_link.sv
logic/pad_ctrl_gen.sv
logic/seg_display.sv
logic/lvds_test.sv
test/tb_lvds_test.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lvds_test \
  -f lvds_test.f -o tb_lvds_test \
  && ./obj_dir/tb_lvds_test > sim.log 2>&1 \
  || echo "compile or run failed"
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* test/tb_checks.svh */
// ##########################################################################
// reference models

// active-low gfedcba with the decimal point dark
function automatic logic [7:0] seg_ref(input logic [3:0] v);
  logic [7:0] pat [16];
  pat = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
          8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};
  return pat[v];
endfunction

// word of the group under test once por has ended
function automatic pad_pkg::pad_ctrl_t word_ref(input logic [7:0] s);
  return {4'b1111, 2'b00, {2{s[3:2]}}, {2{s[4]}}, {2{s[1:0]}}, {2{s[5]}},
          8'h00, {2{s[7:6]}}, 1'b0};
endfunction

// nt in the top 31 bits and sc in the bottom
function automatic logic [123:0] pads_ref(input logic [1:0] g, input logic [7:0] s);
  logic [123:0] all;
  for (int i = 0; i < 4; i++) begin
    all[123 - 31 * i -: 31] = (i == g) ? word_ref(s) : pad_pkg::PAD_IDLE;
  end
  return all;
endfunction

function automatic logic [3:0] nibble_ref(input logic [3:0] sel, input logic [1:0] main,
                                          input logic [7:0] sub, input link_pkg::err_cnt_t e);
  case (sel)
    4'b1101: return sub[7:4];
    4'b1011: return e[7:4];
    4'b0111: return e[3:0];
    default: return {2'b00, main};
  endcase
endfunction

// true when every lane had a 1 somewhere in its last seven bits
function automatic logic lanes_live(input logic [6:0][link_pkg::LANES-1:0] h);
  logic [6:0] lane;
  logic       live;
  live = 1'b1;
  for (int i = 0; i < link_pkg::LANES; i++) begin
    for (int j = 0; j < 7; j++) begin
      lane[j] = h[j][i];
    end
    live = live && (lane != '0);
  end
  return live;
endfunction

task automatic report_mismatch(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
  $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
  test_errs++;
endtask

task automatic report_failure(input string what);
  $display("%s: %s", test_name, what);
  test_errs++;
endtask

// ##########################################################################
// each check is enabled by its own flag

a_reset_sel : assert property (@(posedge clk) chk_reset |-> digit_sel == 4'b1110)
  else report_mismatch("digit_sel", 4'b1110, $sampled(digit_sel));

a_reset_link : assert property (@(posedge clk)
  chk_reset |-> !locked && recv_cnt == '0 && err_cnt == '0)
  else report_mismatch("locked recv_cnt err_cnt", 0,
                       {$sampled(locked), $sampled(recv_cnt), $sampled(err_cnt)});

a_reset_pads : assert property (@(posedge clk)
  chk_reset |-> {et_ctrl, st_ctrl, sc_ctrl} == {3{pad_pkg::PAD_IDLE}})
  else report_mismatch("et st sc words", {3{pad_pkg::PAD_IDLE}},
                       {$sampled(et_ctrl), $sampled(st_ctrl), $sampled(sc_ctrl)});

a_lock_held : assert property (@(posedge clk) chk_lock |-> locked)
  else report_mismatch("locked", 1, $sampled(locked));

a_recv_step : assert property (@(posedge clk)
  chk_lock && prev_locked |-> recv_cnt == prev_recv + 1)
  else report_mismatch("recv_cnt", $sampled(prev_recv) + 1, $sampled(recv_cnt));

// PRBS7 taps sit six and seven bits back
a_dout_prbs : assert property (@(posedge clk)
  chk_lock |-> dout == (dout_hist[5] ^ dout_hist[6]))
  else report_mismatch("dout", $sampled(dout_hist[5]) ^ $sampled(dout_hist[6]),
                       $sampled(dout));

a_dout_live : assert property (@(posedge clk) chk_lock |-> lanes_live(dout_hist))
  else report_failure("a dout lane is stuck at zero");

a_err_count : assert property (@(posedge clk) chk_err |-> err_cnt == exp_err)
  else report_mismatch("err_cnt", $sampled(exp_err), $sampled(err_cnt));

a_pad_words : assert property (@(posedge clk)
  chk_pads |-> {nt_ctrl, et_ctrl, st_ctrl, sc_ctrl} == pads_ref(exp_main, exp_sub))
  else report_mismatch("pad words", pads_ref($sampled(exp_main), $sampled(exp_sub)),
                       {$sampled(nt_ctrl), $sampled(et_ctrl), $sampled(st_ctrl),
                        $sampled(sc_ctrl)});

a_digit : assert property (@(posedge clk)
  chk_disp |-> digit == seg_ref(nibble_ref(digit_sel, exp_main, exp_sub, exp_err)))
  else report_mismatch("digit", seg_ref(nibble_ref($sampled(digit_sel), $sampled(exp_main),
                       $sampled(exp_sub), $sampled(exp_err))), $sampled(digit));

a_scan_seen : assert property (@(posedge clk) chk_seen |-> seen == 4'hf)
  else report_mismatch("digits seen", 4'hf, $sampled(seen));

// counters stay at zero from the clear until the link locks again
a_clr_zero : assert property (@(posedge clk)
  chk_clr && !locked |-> recv_cnt == '0 && err_cnt == '0)
  else report_mismatch("recv_cnt err_cnt", 0, {$sampled(recv_cnt), $sampled(err_cnt)});

/* test/tb_lvds_test.sv */
`timescale 1ns/100ps

module tb_lvds_test;

  localparam int DEBOUNCE = 4;
  localparam int SCAN     = 3;

  logic                       clk   = 1'b0;
  logic                       reset = 1'b1;
  logic                       btn_1 = 1'b0;
  logic                       btn_2 = 1'b0;
  logic                       btn_3 = 1'b0;
  logic [link_pkg::LANES-1:0] flip  = '0;
  logic [link_pkg::LANES-1:0] din;
  logic [link_pkg::LANES-1:0] dout;
  logic [3:0]                 digit_sel;
  logic [7:0]                 digit;
  pad_pkg::pad_ctrl_t         nt_ctrl;
  pad_pkg::pad_ctrl_t         et_ctrl;
  pad_pkg::pad_ctrl_t         st_ctrl;
  pad_pkg::pad_ctrl_t         sc_ctrl;
  link_pkg::recv_cnt_t        recv_cnt;
  link_pkg::err_cnt_t         err_cnt;
  logic                       locked;

  // expected state
  logic [1:0]          exp_main = 2'd0;
  logic [7:0]          exp_sub  = 8'd0;
  link_pkg::err_cnt_t  exp_err  = '0;
  link_pkg::recv_cnt_t prev_recv;
  logic                prev_locked;
  logic [3:0]          seen     = '0;

  // last seven dout values, newest in entry 0
  logic [6:0][link_pkg::LANES-1:0] dout_hist;

  logic chk_reset = 1'b0;
  logic chk_lock  = 1'b0;
  logic chk_err   = 1'b0;
  logic chk_pads  = 1'b0;
  logic chk_disp  = 1'b0;
  logic chk_seen  = 1'b0;
  logic chk_clr   = 1'b0;

  string test_name = "none";
  int    test_errs = 0;
  int    errors    = 0;
  int    tests_run = 0;

  always #2 clk = ~clk;

  // loopback with an optional flipped bit per lane
  assign din = dout ^ flip;

  always @(posedge clk) begin
    prev_recv   <= recv_cnt;
    prev_locked <= locked;
    dout_hist   <= {dout_hist[5:0], dout};
  end

  lvds_test #(
    .DEBOUNCE_CYCLES (DEBOUNCE),
    .SCAN_CYCLES     (SCAN)
  ) DUT (
    .clk       (clk),
    .reset     (reset),
    .btn_1     (btn_1),
    .btn_2     (btn_2),
    .btn_3     (btn_3),
    .din       (din),
    .dout      (dout),
    .digit_sel (digit_sel),
    .digit     (digit),
    .nt_ctrl   (nt_ctrl),
    .et_ctrl   (et_ctrl),
    .st_ctrl   (st_ctrl),
    .sc_ctrl   (sc_ctrl),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .locked    (locked)
  );

  `include "tb_checks.svh"

  function automatic int long_len();
    return DEBOUNCE + 2 + int'($urandom % 4);
  endfunction

  function automatic int short_len();
    return 1 + int'($urandom % (DEBOUNCE - 1));
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    errors += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  task automatic press(input int which, input int cycles);
    @(posedge clk);
    case (which)
      1:       btn_1 <= 1'b1;
      2:       btn_2 <= 1'b1;
      default: btn_3 <= 1'b1;
    endcase
    repeat (cycles) @(posedge clk);
    btn_1 <= 1'b0;
    btn_2 <= 1'b0;
    btn_3 <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic wait_locked(input logic level, input int limit);
    int n;
    n = 0;
    while (locked !== level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (locked !== level) begin
      $display("%s: locked did not go to %0d within %0d cycles", test_name, level, limit);
      test_errs++;
    end
  endtask

  // ##########################################################################
  // test sequence
  initial begin
    int         k;
    logic [1:0] v;
    void'($urandom(32'h2fe8_6a7e));

    begin_test("reset");
    repeat (5) @(posedge clk);
    reset     <= 1'b0;
    chk_reset <= 1'b1;
    @(posedge clk);
    chk_reset <= 1'b0;
    @(posedge clk);
    end_test();

    // two cycles of the lock window are already gone
    begin_test("lock");
    wait_locked(1'b1, link_pkg::LOCK_RUN + 2);
    chk_lock <= 1'b1;
    chk_err  <= 1'b1;
    repeat (20) @(posedge clk);
    end_test();

    begin_test("inject");
    chk_err <= 1'b0;
    k = 0;
    repeat (24) begin
      @(posedge clk);
      v = ($urandom % 3 == 0) ? 2'($urandom % 4) : 2'b00;
      flip <= v;
      k += $countones(v);
    end
    @(posedge clk);
    flip <= '0;
    repeat (4) @(posedge clk);
    exp_err <= exp_err + link_pkg::err_cnt_t'(k);
    chk_err <= 1'b1;
    repeat (4) @(posedge clk);
    end_test();

    // short presses come first and none of them may change anything
    begin_test("buttons");
    chk_pads <= 1'b1;
    press(1, short_len());
    press(2, short_len());
    press(3, short_len());
    repeat (4) begin
      chk_pads <= 1'b0;
      press(1, long_len());
      press(2, long_len());
      repeat (12) @(posedge clk);
      exp_main <= exp_main + 2'd1;
      exp_sub  <= exp_sub + 8'd1;
      chk_pads <= 1'b1;
      repeat (4) @(posedge clk);
    end
    end_test();

    begin_test("display");
    chk_disp <= 1'b1;
    seen     <= '0;
    repeat (4 * SCAN) begin
      @(posedge clk);
      seen <= seen | ~digit_sel;
    end
    @(posedge clk);
    chk_disp <= 1'b0;
    chk_seen <= 1'b1;
    @(posedge clk);
    chk_seen <= 1'b0;
    @(posedge clk);
    end_test();

    begin_test("clear");
    chk_lock <= 1'b0;
    chk_err  <= 1'b0;
    chk_clr  <= 1'b1;
    press(3, long_len());
    wait_locked(1'b0, 4);
    wait_locked(1'b1, link_pkg::LOCK_RUN + 4);
    exp_err  <= '0;
    chk_clr  <= 1'b0;
    chk_lock <= 1'b1;
    chk_err  <= 1'b1;
    repeat (8) @(posedge clk);
    chk_lock <= 1'b0;
    chk_err  <= 1'b0;
    chk_pads <= 1'b0;
    @(posedge clk);
    end_test();

    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
